//--- build.f
+incdir+hdl
hdl/router_pkg.sv
hdl/stream_if.sv
hdl/ingress_stage.sv
hdl/route_compute.sv
hdl/egress_stage.sv
hdl/router_node.sv
tb/router_node_assertions.sv
tb/router_node_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module router_node_tb -f build.f -o router_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/router_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Simulator returned a non-zero status"

grep -q ">>> FAIL" sim.log && { cat sim.log; exit 1; } \
    || { grep -q ">>> PASS" sim.log && { cat sim.log; exit 0; } \
    || { cat sim.log; echo "No result line found in sim.log"; exit 1; }; }

//--- tb/router_node_tb.sv
`timescale 1ns/10ps
`include "router_defines.svh"

module router_node_tb;

    localparam int MAX_BEATS   = 15 + 24 * 4;  // Directed plus worst case random
    localparam int RAND_PKTS   = 24;

    logic                           clk = 1'b0;
    logic                           reset_n;
    router_pkg::node_coord_t        node_addr;
    logic                           in_valid;
    logic                           in_ready;
    logic [`ROUTER_DATA_WIDTH-1:0]  in_data;
    logic                           in_sop;
    logic                           in_eop;
    logic [`ROUTER_EMPTY_WIDTH-1:0] in_empty;
    logic                           out_ready;
    logic                           out_valid;
    logic [`ROUTER_DATA_WIDTH-1:0]  out_data;
    logic                           out_sop;
    logic                           out_eop;
    logic [`ROUTER_EMPTY_WIDTH-1:0] out_empty;
    router_pkg::direction_e         out_channel;

    logic [31:0] lfsr = 32'hb724;
    logic        stall_en = 1'b0;
    logic        stall_now = 1'b0;  // Drawn mid-cycle, applied after the next edge
    int          in_beats = 0;
    int          out_beats = 0;
    int          tests = 0;

    always #4 clk = ~clk;  // 8 ns period

    router_node dut (.*);

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // --------------------
    // Output side
    // --------------------
    always @(negedge clk) begin
        if (reset_n && out_valid && out_ready) out_beats++;
        if (stall_en) begin
            stall_now = (rand_bits(2) == 8'd0);  // About 1 in 4 stalls
        end else begin
            stall_now = 1'b0;
        end
    end

    always @(posedge clk) begin
        #1;
        out_ready = !stall_now;
    end

    // One beat, held until in_ready seen mid-cycle
    task automatic send_beat(input logic [15:0] data, input logic sop,
                             input logic eop, input logic empty);
        logic done;
        in_valid = 1'b1;
        in_data  = data;
        in_sop   = sop;
        in_eop   = eop;
        in_empty = empty;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #1;
        end
        in_beats++;
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input logic [7:0] y, input logic [7:0] x, input int len);
        logic [15:0] word;
        word = {y, x};
        for (int i = 0; i < len; i++) begin
            send_beat(word + i[15:0], i == 0, i == len - 1,
                      (i == len - 1) ? x[0] : 1'b0);  // Empty only on the last beat
        end
    endtask

    task automatic report(input string name);
        tests++;
        $display("Test %s finished, assertion failures so far %0d",
                 name, dut.u_checks.fail_count);
    endtask

    // Watchdog sized from the longest possible run
    initial begin
        repeat (MAX_BEATS * 20) @(posedge clk);
        $display("Watchdog expired, output beats stopped arriving");
        $display(">>> FAIL");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        reset_n   = 1'b0;
        node_addr = '{y: 8'd3, x: 8'd4};
        in_valid  = 1'b0;
        in_data   = '0;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        in_empty  = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset_n = 1'b1;
        @(posedge clk);
        #1;
        report("reset");

        // One header per direction, HERE at the node itself
        send_packet(8'd3, 8'd4, 2);
        send_packet(8'd1, 8'd4, 2);
        send_packet(8'd3, 8'd6, 2);
        send_packet(8'd6, 8'd4, 2);
        send_packet(8'd3, 8'd1, 2);
        report("routing_rule");

        // Back-to-back single beats, then a longer one
        send_packet(8'd3, 8'd7, 1);
        send_packet(8'd3, 8'd1, 1);
        send_packet(8'd3, 8'd4, 3);
        report("single_beat");

        stall_en = 1'b1;
        for (int p = 0; p < RAND_PKTS; p++) begin
            logic [7:0] len;
            logic [7:0] y;
            logic [7:0] x;
            len = rand_bits(2) + 8'd1;
            y   = rand_bits(3);
            x   = rand_bits(3);
            send_packet(y, x, int'(len));
        end
        wait (out_beats == in_beats);
        stall_en = 1'b0;
        repeat (3) @(posedge clk);
        report("random_backpressure");

        $display("Tests %0d, beats in %0d, beats out %0d, failures %0d",
                 tests, in_beats, out_beats, dut.u_checks.fail_count);
        if (dut.u_checks.fail_count == 0 && in_beats == out_beats) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb/router_node_assertions.sv
`timescale 1ns/10ps
`include "router_defines.svh"

module router_node_assertions (
    input logic                           clk,
    input logic                           reset_n,
    input router_pkg::node_coord_t        node_addr,
    input logic                           in_valid,
    input logic                           in_ready,
    input logic                           out_ready,
    input logic                           out_valid,
    input logic [`ROUTER_DATA_WIDTH-1:0]  out_data,
    input logic                           out_sop,
    input logic                           out_eop,
    input logic [`ROUTER_EMPTY_WIDTH-1:0] out_empty,
    input router_pkg::direction_e         out_channel
);

    int                             fail_count = 0;  // Read by the testbench
    int                             in_count;        // Beats accepted at the input
    int                             out_count;       // Beats taken at the output
    router_pkg::direction_e         hdr_channel;     // Channel of the packet's header
    logic [`ROUTER_DATA_WIDTH-1:0]  hdr_data;        // Header word of the packet
    logic [`ROUTER_DATA_WIDTH-1:0]  last_data;       // Previous output beat
    logic [`ROUTER_EMPTY_WIDTH-1:0] exp_empty;       // Empty the stimulus sent for this beat

    // Reference routing rule for a header word
    function automatic router_pkg::direction_e expected_dir(
        input logic [`ROUTER_DATA_WIDTH-1:0] word,
        input router_pkg::node_coord_t       addr
    );
        logic [`ROUTER_COORD_WIDTH-1:0] dy;
        logic [`ROUTER_COORD_WIDTH-1:0] dx;
        dy = word[`ROUTER_DATA_WIDTH-1:`ROUTER_COORD_WIDTH];
        dx = word[`ROUTER_COORD_WIDTH-1:0];
        if (dy == addr.y && dx == addr.x) return router_pkg::HERE;
        if (dy < addr.y) return router_pkg::NORTH;
        if (dx > addr.x) return router_pkg::EAST;
        if (dy > addr.y) return router_pkg::SOUTH;
        return router_pkg::WEST;
    endfunction

    // Stimulus sends bit 0 of the header x as the last empty
    assign exp_empty = !out_eop ? 1'b0 : (out_sop ? out_data[0] : hdr_data[0]);

    // --------------------
    // Reference state
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            in_count    <= 0;
            out_count   <= 0;
            hdr_channel <= router_pkg::HERE;
            hdr_data    <= '0;
            last_data   <= '0;
        end else begin
            if (in_valid && in_ready) in_count <= in_count + 1;
            if (out_valid && out_ready) begin
                out_count <= out_count + 1;
                last_data <= out_data;
                if (out_sop) begin
                    hdr_channel <= out_channel;  // Header sets the packet route
                    hdr_data    <= out_data;
                end
            end
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_reset: assert property (@(posedge clk) !reset_n |=> !out_valid && !in_ready)
        else begin
            fail_count++;
            $error("Reset: out_valid or in_ready high");
        end

    a_route: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && out_sop |-> out_channel == expected_dir(out_data, node_addr))
        else begin
            fail_count++;
            $error("Error route: expected %0d, got %0d",
                expected_dir(out_data, node_addr), out_channel);
        end

    a_hold: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_sop |-> out_channel == hdr_channel)
        else begin
            fail_count++;
            $error("Error hold: expected %0d, got %0d", hdr_channel, out_channel);
        end

    a_order: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_sop |-> out_data == last_data + 1'b1)
        else begin
            fail_count++;
            $error("Error order: expected %h, got %h", last_data + 1'b1, out_data);
        end

    a_empty: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> out_empty == exp_empty)
        else begin
            fail_count++;
            $error("Error empty: expected %0d, got %0d", exp_empty, out_empty);
        end

    a_stall: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_channel)
            && $stable(out_sop) && $stable(out_eop) && $stable(out_empty))
        else begin
            fail_count++;
            $error("Output changed while stalled");
        end

    a_count: assert property (@(posedge clk) disable iff (!reset_n)
        out_count <= in_count && in_count - out_count <= 2)
        else begin
            fail_count++;
            $error("Beat count mismatch, beats lost or duplicated");
        end

endmodule

bind router_node router_node_assertions u_checks (
    .clk         (clk),
    .reset_n     (reset_n),
    .node_addr   (node_addr),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_sop     (out_sop),
    .out_eop     (out_eop),
    .out_empty   (out_empty),
    .out_channel (out_channel)
);

//--- hdl/router_node.sv
`timescale 1ns/10ps
`include "router_defines.svh"

module router_node (
    input  logic                           clk,
    input  logic                           reset_n,
    input  router_pkg::node_coord_t        node_addr,  // Fixed per node

    // Packet input
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [`ROUTER_DATA_WIDTH-1:0]  in_data,
    input  logic                           in_sop,
    input  logic                           in_eop,
    input  logic [`ROUTER_EMPTY_WIDTH-1:0] in_empty,

    // Packet output with its route
    input  logic                           out_ready,
    output logic                           out_valid,
    output logic [`ROUTER_DATA_WIDTH-1:0]  out_data,
    output logic                           out_sop,
    output logic                           out_eop,
    output logic [`ROUTER_EMPTY_WIDTH-1:0] out_empty,
    output router_pkg::direction_e         out_channel
);

    stream_if               routed_in ();  // Ingress to egress, watched by routing
    router_pkg::direction_e channel;       // Route of the beat on routed_in

    // --------------------
    // Stages
    // --------------------
    ingress_stage u_ingress (
        .clk      (clk),
        .reset_n  (reset_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_sop   (in_sop),
        .in_eop   (in_eop),
        .in_empty (in_empty),
        .out      (routed_in.source)
    );

    route_compute u_route (
        .clk       (clk),
        .reset_n   (reset_n),
        .node_addr (node_addr),
        .beats     (routed_in.sink),
        .channel   (channel)
    );

    egress_stage u_egress (
        .clk         (clk),
        .reset_n     (reset_n),
        .beats       (routed_in.sink),
        .channel     (channel),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_sop     (out_sop),
        .out_eop     (out_eop),
        .out_empty   (out_empty),
        .out_channel (out_channel)
    );

endmodule

//--- hdl/egress_stage.sv
`timescale 1ns/10ps
`include "router_defines.svh"

module egress_stage (
    input  logic                           clk,
    input  logic                           reset_n,
    stream_if.sink                         beats,
    input  router_pkg::direction_e         channel,  // Valid with the beat on beats
    input  logic                           out_ready,
    output logic                           out_valid,
    output logic [`ROUTER_DATA_WIDTH-1:0]  out_data,
    output logic                           out_sop,
    output logic                           out_eop,
    output logic [`ROUTER_EMPTY_WIDTH-1:0] out_empty,
    output router_pkg::direction_e         out_channel
);

    logic take;  // Beat moves from ingress into this stage

    // --------------------
    // Handshake
    // --------------------
    assign beats.ready = out_ready || !out_valid;  // Empty or draining
    assign take        = beats.valid && beats.ready;

    // --------------------
    // Valid and channel
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid   <= 1'b0;
            out_channel <= router_pkg::HERE;
        end else begin
            if (take) begin
                out_valid   <= 1'b1;
                out_channel <= channel;  // Captured with its beat
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // --------------------
    // Payload
    // --------------------

    // Held while stalled, take is low then
    always_ff @(posedge clk) begin
        if (take) begin
            out_data  <= beats.data.raw;
            out_sop   <= beats.sop;
            out_eop   <= beats.eop;
            out_empty <= beats.empty;
        end
    end

endmodule

//--- hdl/route_compute.sv
`timescale 1ns/10ps

module route_compute (
    input  logic                    clk,
    input  logic                    reset_n,
    input  router_pkg::node_coord_t node_addr,  // This node's mesh position
    stream_if.sink                  beats,      // Observed only
    output router_pkg::direction_e  channel
);

    router_pkg::node_coord_t dest;      // Header view of the current beat
    router_pkg::direction_e  decision;  // Fresh result for this header
    router_pkg::direction_e  held;      // Route of the packet in flight
    logic                    moves;     // Beat transfers this edge

    assign dest  = beats.data.coord;
    assign moves = beats.valid && beats.ready;

    // --------------------
    // Routing rule
    // --------------------

    // Top left corner is 0,0; north first, then east, south, west
    always_comb begin
        if (dest.y == node_addr.y && dest.x == node_addr.x) begin
            decision = router_pkg::HERE;   // Arrived
        end else if (dest.y < node_addr.y) begin
            decision = router_pkg::NORTH;
        end else if (dest.x > node_addr.x) begin
            decision = router_pkg::EAST;
        end else if (dest.y > node_addr.y) begin
            decision = router_pkg::SOUTH;
        end else begin
            decision = router_pkg::WEST;   // Same row, smaller x
        end
    end

    // --------------------
    // Hold for the packet
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            held <= router_pkg::HERE;
        end else if (moves && beats.eop) begin
            // Also covers single-beat packets, nothing stale left behind
            held <= router_pkg::HERE;
        end else if (moves && beats.sop) begin
            held <= decision;
        end
    end

    // Header uses the live result, body beats the held one
    assign channel = beats.sop ? decision : held;

endmodule

//--- hdl/ingress_stage.sv
`timescale 1ns/10ps
`include "router_defines.svh"

module ingress_stage (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [`ROUTER_DATA_WIDTH-1:0]  in_data,
    input  logic                           in_sop,
    input  logic                           in_eop,
    input  logic [`ROUTER_EMPTY_WIDTH-1:0] in_empty,
    stream_if.source                       out
);

    logic started;    // Set on the first edge out of reset
    logic in_packet;  // Header taken, eop not yet seen
    logic accept;     // Input beat moves this edge

    // --------------------
    // Handshake
    // --------------------

    // Free slot or slot drains this edge
    assign in_ready = started && (out.ready || !out.valid);
    assign accept   = in_valid && in_ready;

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            started   <= 1'b0;
            in_packet <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            started <= 1'b1;

            if (accept) begin
                out.valid <= 1'b1;
            end else if (out.ready) begin
                out.valid <= 1'b0;  // Downstream took the last beat
            end

            // Packet framing as seen at the input
            if (accept && in_eop) begin
                in_packet <= 1'b0;
            end else if (accept && in_sop) begin
                in_packet <= 1'b1;  // Multi-beat packet opened
            end
        end
    end

    // --------------------
    // Payload register
    // --------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            out.data.raw <= in_data;
            out.sop      <= in_sop && !in_packet;  // Stray sop mid-packet ignored
            out.eop      <= in_eop;
            out.empty    <= in_empty;
        end
    end

endmodule

//--- hdl/stream_if.sv
`timescale 1ns/10ps
`include "router_defines.svh"

// Packet stream between the node's stages
interface stream_if;

    logic                           valid;  // Beat present
    logic                           ready;  // Sink can take it
    router_pkg::beat_word_u         data;
    logic                           sop;    // Header beat
    logic                           eop;    // Last beat of packet
    logic [`ROUTER_EMPTY_WIDTH-1:0] empty;  // Unused symbols, last beat only

    // Upstream side
    modport source (
        output valid,
        output data,
        output sop,
        output eop,
        output empty,
        input  ready
    );

    // Downstream side
    modport sink (
        input  valid,
        input  data,
        input  sop,
        input  eop,
        input  empty,
        output ready
    );

endinterface

//--- hdl/router_pkg.sv
`include "router_defines.svh"

package router_pkg;

    // Output channel numbering of the node
    typedef enum logic [`ROUTER_DIR_WIDTH-1:0] {
        HERE  = 0,  // Delivered to this node
        NORTH = 1,  // Towards smaller y
        SOUTH = 2,  // Towards larger y
        EAST  = 3,  // Towards larger x
        WEST  = 4   // Towards smaller x
    } direction_e;

    // Mesh position, y in the upper half
    typedef struct packed {
        logic [`ROUTER_COORD_WIDTH-1:0] y;
        logic [`ROUTER_COORD_WIDTH-1:0] x;
    } node_coord_t;

    // One beat, seen as payload or as header
    typedef union packed {
        logic [`ROUTER_DATA_WIDTH-1:0] raw;    // Body beats
        node_coord_t                   coord;  // Header beat, destination
    } beat_word_u;

endpackage

//--- hdl/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// --------------------
// Beat layout
// --------------------

// Two 8-bit symbols per beat
`define ROUTER_DATA_WIDTH 16

// Header splits the beat into {y, x}
`define ROUTER_COORD_WIDTH (`ROUTER_DATA_WIDTH / 2)

// Unused symbols on the last beat, 0 or 1
`define ROUTER_EMPTY_WIDTH 1

// --------------------
// Route output
// --------------------

// Five directions fit in 3 bits
`define ROUTER_DIR_WIDTH 3

`endif
